// ==== flist.f ====
+incdir+source
source/idct_pkg.sv
source/dp_ram.sv
source/block_transfer.sv
source/idct_stage.sv
source/idct_ctrl.sv
source/idct_top.sv
test/idct_props.sv
test/idct_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the IDCT testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module idct_tb \
	-Mdir obj_dir -o idct_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "verilator build failed, see build.log"
	exit 1
fi

./obj_dir/idct_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see sim.log"
	exit 1
fi

if grep -q "TESTS FAILED" sim.log; then
	echo "testbench reported a failure, see sim.log"
	exit 1
fi

echo "simulation passed"
exit 0

// ==== source/block_transfer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "idct_config.svh"

module block_transfer (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic go_fetch,
	input logic go_write,
	input logic [`IDCT_BX_W-1:0] block_x,
	input logic [`IDCT_BY_W-1:0] block_y,
	input logic [15:0] sram_read_data,
	output idct_pkg::sram_addr_t sram_address,
	output idct_pkg::sram_word_u sram_write_data,
	output logic write_en_n,
	output idct_pkg::ram_port_t buf_port,
	input idct_pkg::coef_pair_t buf_q,
	output logic fetch_done,
	output logic write_done
);
	import idct_pkg::*;

	localparam int LAT = `IDCT_SRAM_LATENCY;

	sram_word_u rd_word;
	sram_addr_t src_base, dst_addr;
	// fetch issue side and the index delayed to match read data
	logic f_active;
	logic [5:0] f_cnt;
	logic f_v [LAT];
	logic [5:0] f_idx [LAT];
	coef_t even_hold;
	logic bw_we;
	buf_addr_t bw_addr;
	coef_pair_t bw_data;
	// write-back, one buffer word per sram word
	logic w_active, w_v;
	logic [4:0] w_cnt, w_idx;

	function automatic pixel_t clip(input coef_t v);
		if (v < 0) return 8'd0;
		if (v > 255) return 8'd255;
		return v[7:0];
	endfunction

	assign rd_word = sram_read_data;
	assign src_base = sram_addr_t'(`IDCT_SRC_BASE)
		+ sram_addr_t'({block_y, 3'd0}) * sram_addr_t'(`IDCT_SRC_STRIDE)
		+ sram_addr_t'({block_x, 3'd0});
	assign dst_addr = sram_addr_t'(`IDCT_DST_BASE)
		+ sram_addr_t'({block_y, w_idx[4:2]}) * sram_addr_t'(`IDCT_DST_STRIDE)
		+ sram_addr_t'({block_x, w_idx[1:0]});
	assign buf_port = '{addr: (w_active ? w_cnt : bw_addr), data: bw_data, we: bw_we};

	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			f_active <= 1'b0;
			f_cnt <= '0;
			f_v <= '{default: 1'b0};
			bw_we <= 1'b0;
			fetch_done <= 1'b0;
			w_active <= 1'b0;
			w_cnt <= '0;
			w_v <= 1'b0;
			write_en_n <= 1'b1;
			write_done <= 1'b0;
		end else begin
			if (go_fetch) begin
				f_active <= 1'b1;
				f_cnt <= '0;
			end else if (f_active) begin
				f_cnt <= f_cnt + 6'd1;
				if (f_cnt == 6'd63) f_active <= 1'b0;
			end
			f_v[0] <= f_active;
			for (int i = 1; i < LAT; i++) begin
				f_v[i] <= f_v[i-1];
			end
			// odd column completes a pair
			bw_we <= f_v[LAT-1] && f_idx[LAT-1][0];
			fetch_done <= f_v[LAT-1] && (f_idx[LAT-1] == 6'd63);

			if (go_write) begin
				w_active <= 1'b1;
				w_cnt <= '0;
			end else if (w_active) begin
				w_cnt <= w_cnt + 5'd1;
				if (w_cnt == 5'd31) w_active <= 1'b0;
			end
			w_v <= w_active;
			write_en_n <= !w_v;
			write_done <= w_v && (w_idx == 5'd31);
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		f_idx[0] <= f_cnt;
		for (int i = 1; i < LAT; i++) begin
			f_idx[i] <= f_idx[i-1];
		end
		if (f_v[LAT-1]) begin
			if (!f_idx[LAT-1][0]) begin
				even_hold <= rd_word.coef;
			end else begin
				bw_addr <= f_idx[LAT-1][5:1];
				bw_data <= '{even: even_hold, odd: rd_word.coef};
			end
		end

		// row end jumps to the next image row of the block
		if (go_fetch) begin
			sram_address <= src_base;
		end else if (f_active) begin
			if (f_cnt[2:0] == 3'd7) begin
				sram_address <= sram_address + sram_addr_t'(`IDCT_SRC_STRIDE - 7);
			end else begin
				sram_address <= sram_address + 18'd1;
			end
		end else if (w_v) begin
			sram_address <= dst_addr;
		end

		w_idx <= w_cnt;
		if (w_v) begin
			sram_write_data.pix <= '{even: clip(buf_q.even), odd: clip(buf_q.odd)};
		end
	end

endmodule

`default_nettype wire

// ==== source/dp_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module dp_ram (
	input logic CLOCK_50_I,
	input idct_pkg::ram_port_t a,
	input idct_pkg::ram_port_t b,
	output idct_pkg::coef_pair_t q_a,
	output idct_pkg::coef_pair_t q_b
);
	import idct_pkg::*;

	// 8 rows of 4 coefficient pairs
	coef_pair_t mem [32];

	// read returns the old word on a same-cycle write
	always_ff @(posedge CLOCK_50_I) begin
		if (a.we) begin
			mem[a.addr] <= a.data;
		end
		if (b.we) begin
			mem[b.addr] <= b.data;
		end
		q_a <= mem[a.addr];
		q_b <= mem[b.addr];
	end

endmodule

`default_nettype wire

// ==== source/idct_config.svh ====
`ifndef IDCT_CONFIG_SVH
`define IDCT_CONFIG_SVH

// image size in 8x8 blocks
`define IDCT_BLOCKS_X 4
`define IDCT_BLOCKS_Y 2

// block counter widths
`define IDCT_BX_W 2
`define IDCT_BY_W 1

// coefficient words first, pixel pairs above them
`define IDCT_SRC_BASE 0
`define IDCT_DST_BASE 1024
`define IDCT_SRC_STRIDE (`IDCT_BLOCKS_X * 8)
`define IDCT_DST_STRIDE (`IDCT_BLOCKS_X * 4)

// read data is valid this many cycles after its address
`define IDCT_SRAM_LATENCY 2

// arithmetic right shifts after each pass
`define IDCT_T_SHIFT 8
`define IDCT_S_SHIFT 16

`endif

// ==== source/idct_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "idct_config.svh"

module idct_ctrl (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic start,
	input logic fetch_done,
	input logic write_done,
	input logic t_done,
	input logic s_done,
	output logic go_fetch,
	output logic go_write,
	output logic go_t,
	output logic go_s,
	output logic [`IDCT_BX_W-1:0] block_x,
	output logic [`IDCT_BY_W-1:0] block_y,
	input idct_pkg::ram_port_t xfer_port,
	input idct_pkg::ram_port_t t_rd_port,
	input idct_pkg::ram_port_t s_wr_port,
	output idct_pkg::ram_port_t a_port_a,
	output idct_pkg::ram_port_t a_port_b,
	output logic finish
);
	import idct_pkg::*;

	phase_t phase;
	logic last_x;
	logic last_y;

	assign last_x = (block_x == `IDCT_BX_W'(`IDCT_BLOCKS_X - 1));
	assign last_y = (block_y == `IDCT_BY_W'(`IDCT_BLOCKS_Y - 1));
	assign finish = (phase == done);

	// buffer A routing, pass_s only ever writes through port b
	always_comb begin
		a_port_a = t_rd_port;
		a_port_b = s_wr_port;
		case (phase)
			fetch: begin
				// fetch writes go through port b only
				a_port_a = xfer_port;
				a_port_a.we = 1'b0;
				a_port_b = xfer_port;
			end
			write: a_port_a = xfer_port;
			default: ;
		endcase
	end

	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			phase <= idle;
			block_x <= '0;
			block_y <= '0;
			go_fetch <= 1'b0;
			go_write <= 1'b0;
			go_t <= 1'b0;
			go_s <= 1'b0;
		end else begin
			go_fetch <= 1'b0;
			go_write <= 1'b0;
			go_t <= 1'b0;
			go_s <= 1'b0;
			case (phase)
				idle: if (start) begin
					phase <= fetch;
					go_fetch <= 1'b1;
					block_x <= '0;
					block_y <= '0;
				end
				fetch: if (fetch_done) begin
					phase <= pass_t;
					go_t <= 1'b1;
				end
				pass_t: if (t_done) begin
					phase <= pass_s;
					go_s <= 1'b1;
				end
				pass_s: if (s_done) begin
					phase <= write;
					go_write <= 1'b1;
				end
				write: if (write_done) begin
					if (last_x && last_y) begin
						phase <= done;
					end else begin
						phase <= fetch;
						go_fetch <= 1'b1;
						// block-row-major traversal
						if (last_x) begin
							block_x <= '0;
							block_y <= block_y + `IDCT_BY_W'(1);
						end else begin
							block_x <= block_x + `IDCT_BX_W'(1);
						end
					end
				end
				done: phase <= idle;
				default: phase <= idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/idct_pkg.sv ====
`default_nettype none

package idct_pkg;

	typedef logic [17:0] sram_addr_t;
	typedef logic signed [15:0] coef_t;
	typedef logic signed [31:0] acc_t;
	typedef logic [7:0] pixel_t;
	typedef logic [4:0] buf_addr_t;
	typedef logic signed [11:0] cos_t;

	// high byte is the even column
	typedef struct packed {
		pixel_t even;
		pixel_t odd;
	} pixel_pair_t;

	// one sram word, a coefficient on fetch or a pixel pair on write-back
	typedef union packed {
		coef_t coef;
		pixel_pair_t pix;
	} sram_word_u;

	typedef struct packed {
		coef_t even;
		coef_t odd;
	} coef_pair_t;

	typedef struct packed {
		buf_addr_t addr;
		coef_pair_t data;
		logic we;
	} ram_port_t;

	typedef enum logic [2:0] {idle, fetch, pass_t, pass_s, write, done} phase_t;

	// 4096 * c_k * cos((2n+1)k*pi/16), indexed [k][n]
	localparam cos_t idct_coeff [8][8] = '{
		'{ 1448,  1448,  1448,  1448,  1448,  1448,  1448,  1448},
		'{ 2009,  1703,  1138,   400,  -400, -1138, -1703, -2009},
		'{ 1892,   784,  -784, -1892, -1892,  -784,   784,  1892},
		'{ 1703,  -400, -2009, -1138,  1138,  2009,   400, -1703},
		'{ 1448, -1448, -1448,  1448,  1448, -1448, -1448,  1448},
		'{ 1138, -2009,   400,  1703, -1703,  -400,  2009, -1138},
		'{  784, -1892,  1892,  -784,  -784,  1892, -1892,   784},
		'{  400, -1138,  1703, -2009,  2009, -1703,  1138,  -400}
	};

endpackage

`default_nettype wire

// ==== source/idct_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module idct_stage #(
	parameter int SHIFT = 8
) (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic go,
	output idct_pkg::ram_port_t rd_port,
	output idct_pkg::ram_port_t wr_port,
	input idct_pkg::coef_pair_t rd_q,
	output logic done
);
	import idct_pkg::*;

	// issue order is {m, n, row parity, j}, row r = 2m + parity
	logic active;
	logic [7:0] cnt;

	// fields of the read that rd_q currently answers
	logic s1_v;
	logic [7:0] s1_cnt;
	logic [1:0] s1_m;
	logic [2:0] s1_n;
	logic s1_odd;
	logic [1:0] s1_j;

	acc_t acc;
	acc_t prod_even;
	acc_t prod_odd;
	acc_t sum;
	acc_t scaled;
	coef_t even_hold;

	logic wr_we;
	buf_addr_t wr_addr;
	coef_pair_t wr_data;

	// pair j of row r sits at r*4 + j
	assign rd_port = '{addr: {cnt[7:6], cnt[2:0]}, data: '0, we: 1'b0};
	assign wr_port = '{addr: wr_addr, data: wr_data, we: wr_we};

	assign {s1_m, s1_n, s1_odd, s1_j} = s1_cnt;

	// two multipliers, one per half of the pair
	assign prod_even = acc_t'(rd_q.even) * acc_t'(idct_coeff[{s1_j, 1'b0}][s1_n]);
	assign prod_odd = acc_t'(rd_q.odd) * acc_t'(idct_coeff[{s1_j, 1'b1}][s1_n]);

	// first pair of a row starts a fresh sum
	assign sum = ((s1_j == 2'd0) ? acc_t'(0) : acc) + prod_even + prod_odd;
	assign scaled = sum >>> SHIFT;

	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			active <= 1'b0;
			cnt <= '0;
			s1_v <= 1'b0;
			wr_we <= 1'b0;
			done <= 1'b0;
		end else begin
			if (go) begin
				active <= 1'b1;
				cnt <= '0;
			end else if (active) begin
				cnt <= cnt + 8'd1;
				if (cnt == 8'hff) active <= 1'b0;
			end
			s1_v <= active;
			wr_we <= s1_v && s1_odd && (s1_j == 2'd3);
			// raised together with the last transposed write
			done <= s1_v && (s1_cnt == 8'hff);
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		s1_cnt <= cnt;
		acc <= sum;
		if (s1_j == 2'd3) begin
			if (!s1_odd) begin
				even_hold <= coef_t'(scaled);
			end else begin
				// Y[2m][n] and Y[2m+1][n] land at n*4 + m
				wr_addr <= {s1_n, s1_m};
				wr_data <= '{even: even_hold, odd: coef_t'(scaled)};
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/idct_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "idct_config.svh"

module idct_top (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic start,
	input logic [15:0] sram_read_data,
	output logic [15:0] sram_write_data,
	output idct_pkg::sram_addr_t sram_address,
	output logic write_en_n,
	output logic finish
);
	import idct_pkg::*;

	logic go_fetch, go_write, go_t, go_s;
	logic fetch_done, write_done, t_done, s_done;
	logic [`IDCT_BX_W-1:0] block_x;
	logic [`IDCT_BY_W-1:0] block_y;

	// buffer A holds S' and then S, buffer B holds T transposed
	ram_port_t xfer_port, t_rd_port, s_wr_port;
	ram_port_t a_port_a, a_port_b;
	ram_port_t t_wr_port, s_rd_port;
	coef_pair_t a_q_a, b_q_b;

	idct_ctrl ctrl (.*);

	block_transfer xfer (
		.*,
		.sram_write_data(sram_write_data),
		.buf_port(xfer_port),
		.buf_q(a_q_a)
	);

	dp_ram buf_a (
		.CLOCK_50_I,
		.a(a_port_a),
		.b(a_port_b),
		.q_a(a_q_a),
		.q_b()
	);

	dp_ram buf_b (
		.CLOCK_50_I,
		.a(t_wr_port),
		.b(s_rd_port),
		.q_a(),
		.q_b(b_q_b)
	);

	idct_stage #(.SHIFT(`IDCT_T_SHIFT)) stage_t (
		.CLOCK_50_I, .Resetn,
		.go(go_t), .done(t_done),
		.rd_port(t_rd_port), .rd_q(a_q_a),
		.wr_port(t_wr_port)
	);

	idct_stage #(.SHIFT(`IDCT_S_SHIFT)) stage_s (
		.CLOCK_50_I, .Resetn,
		.go(go_s), .done(s_done),
		.rd_port(s_rd_port), .rd_q(b_q_b),
		.wr_port(s_wr_port)
	);

endmodule

`default_nettype wire

// ==== test/idct_props.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "idct_config.svh"

module idct_props (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic start,
	input logic write_en_n,
	input logic finish,
	input idct_pkg::sram_addr_t sram_address
);
	localparam idct_pkg::sram_addr_t DST_LO = `IDCT_DST_BASE;
	localparam idct_pkg::sram_addr_t DST_HI =
		`IDCT_DST_BASE + `IDCT_BLOCKS_X * `IDCT_BLOCKS_Y * 32;

	// set by the first start after reset
	logic started;

	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			started <= 1'b0;
		end else if (start) begin
			started <= 1'b1;
		end
	end

	finish_single: assert property (@(posedge CLOCK_50_I) disable iff (!Resetn)
		finish |=> !finish)
		else $error("finish stayed high for more than one cycle");

	quiet_before_start: assert property (@(posedge CLOCK_50_I) disable iff (!Resetn)
		!started |-> write_en_n)
		else $error("write_en_n went low before the first start");

	write_in_dst: assert property (@(posedge CLOCK_50_I) disable iff (!Resetn)
		!write_en_n |-> (sram_address >= DST_LO && sram_address < DST_HI))
		else $error("sram write outside the pixel region");

endmodule

bind idct_top idct_props props (.*);

`default_nettype wire

// ==== test/idct_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "idct_config.svh"

module idct_tb;
	import idct_pkg::*;

	localparam int LAT = `IDCT_SRAM_LATENCY;
	localparam int ROWS = `IDCT_BLOCKS_Y * 8;
	localparam int COLS = `IDCT_BLOCKS_X * 8;
	localparam int PAIRS = ROWS * COLS / 2;
	localparam int MEM_WORDS = 2048;
	localparam int TIMEOUT = 50000;
	// block (1,0) is pushed past the pixel range, block (2,0) keeps only its DC term
	localparam int BIG_BX = 1;
	localparam int DC_BX = 2;

	logic CLOCK_50_I = 1'b0;
	logic Resetn = 1'b0;
	logic start = 1'b0;
	logic [15:0] sram_read_data = '0;
	sram_word_u sram_write_data;
	sram_addr_t sram_address;
	logic write_en_n;
	logic finish;

	// sram contents, read pipeline and captured pixel pairs
	logic [15:0] mem [MEM_WORDS];
	logic [15:0] rd_pipe [LAT] = '{default: '0};
	sram_word_u out_mem [PAIRS];
	sram_word_u first_run [PAIRS];
	int wr_count [PAIRS] = '{default: 0};
	int writes = 0;
	int finishes = 0;

	// model state
	int coef [ROWS][COLS];
	int raw_s [ROWS][COLS];
	pixel_t exp_pix [ROWS][COLS];

	idct_top UUT (
		.CLOCK_50_I(CLOCK_50_I),
		.Resetn(Resetn),
		.start(start),
		.sram_read_data(sram_read_data),
		.sram_write_data(sram_write_data),
		.sram_address(sram_address),
		.write_en_n(write_en_n),
		.finish(finish)
	);

	always #10 CLOCK_50_I = ~CLOCK_50_I;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_pixels(input string name, input sram_word_u got, input sram_word_u want);
		if (got !== want) begin
			abort_run($sformatf("Fail at %0t ns: %s = %04h, expected %04h",
				$time, name, got, want));
		end
	endtask

	task automatic check_addr(input string name, input sram_addr_t got, input sram_addr_t want);
		if (got !== want) begin
			abort_run($sformatf("Fail at %0t ns: %s = %0d, expected %0d",
				$time, name, got, want));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic want);
		if (got !== want) begin
			abort_run($sformatf("Fail at %0t ns: %s = %b, expected %b",
				$time, name, got, want));
		end
	endtask

	function automatic pixel_t to_pixel(input int v);
		if (v < 0) begin
			return 8'd0;
		end
		if (v > 255) begin
			return 8'd255;
		end
		return pixel_t'(v);
	endfunction

	// k-th write of a run, blocks in row-major order, pairs row by row
	function automatic sram_addr_t expected_addr(input int k);
		int blk;
		int w;
		blk = k / 32;
		w = k % 32;
		return sram_addr_t'(`IDCT_DST_BASE
			+ ((blk / `IDCT_BLOCKS_X) * 8 + w / 4) * (COLS / 2)
			+ (blk % `IDCT_BLOCKS_X) * 4 + w % 4);
	endfunction

	task automatic fill_image();
		int v;
		for (int a = 0; a < MEM_WORDS; a++) begin
			mem[a] = 16'(a * 40503) ^ 16'h5a5a;
		end
		for (int r = 0; r < ROWS; r++) begin
			for (int c = 0; c < COLS; c++) begin
				v = int'($urandom % 1024) - 512;
				if (r < 8 && c / 8 == DC_BX && (r != 0 || c % 8 != 0)) begin
					v = 0;
				end else if (r < 8 && c / 8 == BIG_BX) begin
					// strong DC and first vertical term, small AC elsewhere
					if (r == 0 && c % 8 == 0) begin
						v = 1024;
					end else if (r == 1 && c % 8 == 0) begin
						v = 2800;
					end else begin
						v = v / 16;
					end
				end
				coef[r][c] = v;
				mem[`IDCT_SRC_BASE + r * COLS + c] = 16'(v);
			end
		end
	endtask

	// T = S'.C truncated to 16 bits, then S = C^T.T
	function automatic void model_block(input int bx, input int by);
		int t [8][8];
		int acc;
		coef_t v;
		for (int r = 0; r < 8; r++) begin
			for (int n = 0; n < 8; n++) begin
				acc = 0;
				for (int k = 0; k < 8; k++) begin
					acc += coef[by * 8 + r][bx * 8 + k] * int'(idct_coeff[k][n]);
				end
				v = coef_t'(acc >>> `IDCT_T_SHIFT);
				t[r][n] = int'(v);
			end
		end
		for (int n = 0; n < 8; n++) begin
			for (int r = 0; r < 8; r++) begin
				acc = 0;
				for (int k = 0; k < 8; k++) begin
					acc += int'(idct_coeff[k][n]) * t[k][r];
				end
				v = coef_t'(acc >>> `IDCT_S_SHIFT);
				raw_s[by * 8 + n][bx * 8 + r] = int'(v);
				exp_pix[by * 8 + n][bx * 8 + r] = to_pixel(int'(v));
			end
		end
	endfunction

	task automatic record_write();
		int off;
		int row;
		int j;
		sram_word_u want;
		if (writes >= PAIRS * (finishes + 1)) begin
			abort_run("more pixel writes than the image holds before finish");
		end
		check_addr("sram_address", sram_address, expected_addr(writes % PAIRS));
		off = int'(sram_address) - `IDCT_DST_BASE;
		row = off / (COLS / 2);
		j = off % (COLS / 2);
		want.pix.even = exp_pix[row][2 * j];
		want.pix.odd = exp_pix[row][2 * j + 1];
		check_pixels($sformatf("sram_write_data@%0d", sram_address), sram_write_data, want);
		out_mem[off] = sram_write_data;
		wr_count[off]++;
		writes++;
	endtask

	// sram model and write capture, all on the falling edge
	always @(negedge CLOCK_50_I) begin
		sram_read_data = rd_pipe[LAT - 1];
		for (int i = LAT - 1; i > 0; i--) begin
			rd_pipe[i] = rd_pipe[i - 1];
		end
		if (sram_address < sram_addr_t'(MEM_WORDS)) begin
			rd_pipe[0] = mem[sram_address[10:0]];
		end else begin
			rd_pipe[0] = '0;
		end
		if (Resetn && !write_en_n) begin
			record_write();
		end
		if (Resetn && finish) begin
			if (writes != PAIRS * (finishes + 1)) begin
				abort_run($sformatf("finish came after %0d pixel writes instead of %0d",
					writes, PAIRS * (finishes + 1)));
			end
			finishes++;
		end
	end

	task automatic run_image(input int n);
		int cycles;
		@(negedge CLOCK_50_I);
		start = 1'b1;
		@(negedge CLOCK_50_I);
		start = 1'b0;
		cycles = 0;
		while (finishes < n) begin
			@(negedge CLOCK_50_I);
			cycles++;
			if (cycles > TIMEOUT) begin
				abort_run($sformatf("timed out waiting for finish of run %0d", n));
			end
		end
	endtask

	task automatic verify_write_counts(input int runs);
		for (int i = 0; i < PAIRS; i++) begin
			if (wr_count[i] != runs) begin
				abort_run($sformatf("pixel pair %0d written %0d times over %0d runs",
					i, wr_count[i], runs));
			end
		end
	endtask

	// out of range values in the large block must saturate
	task automatic verify_clipping();
		sram_word_u word;
		pixel_t got;
		pixel_t want;
		int highs;
		int lows;
		highs = 0;
		lows = 0;
		for (int r = 0; r < 8; r++) begin
			for (int c = BIG_BX * 8; c < BIG_BX * 8 + 8; c++) begin
				word = out_mem[r * (COLS / 2) + c / 2];
				got = (c % 2 == 1) ? word.pix.odd : word.pix.even;
				if (raw_s[r][c] > 255 || raw_s[r][c] < 0) begin
					want = (raw_s[r][c] > 255) ? 8'd255 : 8'd0;
					highs += (raw_s[r][c] > 255) ? 1 : 0;
					lows += (raw_s[r][c] < 0) ? 1 : 0;
					check_pixels($sformatf("pixel[%0d][%0d]", r, c),
						sram_word_u'({got, 8'd0}), sram_word_u'({want, 8'd0}));
				end
			end
		end
		if (highs == 0 || lows == 0) begin
			abort_run("large block does not leave the pixel range on both sides");
		end
	endtask

	initial begin
		void'($urandom(32'he89c8ebf));
		fill_image();
		for (int by = 0; by < `IDCT_BLOCKS_Y; by++) begin
			for (int bx = 0; bx < `IDCT_BLOCKS_X; bx++) begin
				model_block(bx, by);
			end
		end
		repeat (10) @(negedge CLOCK_50_I);
		Resetn = 1'b1;
		// nothing moves until the first start
		repeat (20) begin
			@(negedge CLOCK_50_I);
			check_flag("write_en_n", write_en_n, 1'b1);
			check_flag("finish", finish, 1'b0);
		end
		run_image(1);
		verify_write_counts(1);
		verify_clipping();
		first_run = out_mem;
		run_image(2);
		verify_write_counts(2);
		for (int i = 0; i < PAIRS; i++) begin
			check_pixels($sformatf("second run pair %0d", i), out_mem[i], first_run[i]);
		end
		repeat (10) @(negedge CLOCK_50_I);
		if (finishes != 2) begin
			abort_run($sformatf("finish pulsed %0d times over two runs", finishes));
		end
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire
